// File: Makefile
TOP = tb_riscv_core

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | awk '{ print } /^Test completed successfully$$/ { ok = 1 } END { exit !ok }'

obj_dir/V$(TOP): build.f hw/*.sv tb/*.sv
	verilator --binary --top-module $(TOP) -f build.f

lint:
	verilator --lint-only -Wall --top-module riscv_core \
	  hw/riscv_pkg.sv hw/riscv_if_stage.sv hw/riscv_register_file.sv \
	  hw/riscv_id_stage.sv hw/riscv_ex_stage.sv hw/riscv_core.sv

clean:
	rm -rf obj_dir

// File: build.f
hw/riscv_pkg.sv
hw/riscv_if_stage.sv
hw/riscv_register_file.sv
hw/riscv_id_stage.sv
hw/riscv_ex_stage.sv
hw/riscv_core.sv
tb/tb_riscv_core.sv

// File: hw/riscv_core.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_core (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        fetch_enable_i,
  input  logic [riscv_pkg::XLEN-1:0]  boot_addr_i,

  // instruction memory
  output logic                        instr_req_o,
  output logic [riscv_pkg::XLEN-1:0]  instr_addr_o,
  input  logic                        instr_gnt_i,
  input  logic                        instr_rvalid_i,
  input  logic [riscv_pkg::XLEN-1:0]  instr_rdata_i,

  output riscv_pkg::retire_t          retire_o
);

  riscv_pkg::if_id_t                if_id;     // IF -> ID
  riscv_pkg::id_ex_t                id_ex;     // ID -> EX
  riscv_pkg::rf_wr_t                rf_wr;     // EX -> regfile, bypass
  logic [riscv_pkg::REG_ADDR_W-1:0] raddr_a;
  logic [riscv_pkg::REG_ADDR_W-1:0] raddr_b;
  logic [riscv_pkg::XLEN-1:0]       rdata_a;
  logic [riscv_pkg::XLEN-1:0]       rdata_b;

  ////////////////////////////////////////////////////////////////////////////
  // fetch
  ////////////////////////////////////////////////////////////////////////////

  riscv_if_stage if_stage_i (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .if_id_o        ( if_id          )
  );

  ////////////////////////////////////////////////////////////////////////////
  // decode and register file
  ////////////////////////////////////////////////////////////////////////////

  riscv_id_stage id_stage_i (
    .clk_i     ( clk_i    ),
    .arst_n_i  ( arst_n_i ),
    .if_id_i   ( if_id    ),
    .raddr_a_o ( raddr_a  ),
    .raddr_b_o ( raddr_b  ),
    .rdata_a_i ( rdata_a  ),
    .rdata_b_i ( rdata_b  ),
    .bypass_i  ( rf_wr    ),  // forward from EX
    .id_ex_o   ( id_ex    )
  );

  riscv_register_file registers_i (
    .clk_i     ( clk_i    ),
    .arst_n_i  ( arst_n_i ),
    .raddr_a_i ( raddr_a  ),
    .raddr_b_i ( raddr_b  ),
    .rdata_a_o ( rdata_a  ),
    .rdata_b_o ( rdata_b  ),
    .wr_i      ( rf_wr    )
  );

  // execute and retire
  riscv_ex_stage ex_stage_i (
    .clk_i    ( clk_i    ),
    .arst_n_i ( arst_n_i ),
    .id_ex_i  ( id_ex    ),
    .rf_wr_o  ( rf_wr    ),
    .retire_o ( retire_o )
  );

endmodule

`default_nettype wire

// File: hw/riscv_ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_ex_stage (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  riscv_pkg::id_ex_t  id_ex_i,
  output riscv_pkg::rf_wr_t  rf_wr_o,   // to regfile and decode bypass
  output riscv_pkg::retire_t retire_o
);

  logic [riscv_pkg::XLEN-1:0] alu_result;
  logic [riscv_pkg::XLEN-1:0] op_a;
  logic [riscv_pkg::XLEN-1:0] op_b;
  logic                       rf_we;

  assign op_a = id_ex_i.operand_a;
  assign op_b = id_ex_i.operand_b;

  ////////////////////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (id_ex_i.alu_op)
      riscv_pkg::ALU_ADD: alu_result = op_a + op_b;
      riscv_pkg::ALU_SUB: alu_result = op_a - op_b;
      riscv_pkg::ALU_AND: alu_result = op_a & op_b;
      riscv_pkg::ALU_OR:  alu_result = op_a | op_b;
      riscv_pkg::ALU_XOR: alu_result = op_a ^ op_b;
      riscv_pkg::ALU_SLT: alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      riscv_pkg::ALU_SLL: alu_result = op_a << op_b[4:0];  // shamt low 5 bits
      riscv_pkg::ALU_SRL: alu_result = op_a >> op_b[4:0];
      default:            alu_result = '0;
    endcase
  end

  // write only for valid legal instr, never x0
  assign rf_we = id_ex_i.valid && id_ex_i.we && !id_ex_i.illegal
                 && (id_ex_i.rd != '0);

  assign rf_wr_o.we    = rf_we;
  assign rf_wr_o.waddr = id_ex_i.rd;
  assign rf_wr_o.wdata = alu_result;

  // retire record, one cycle after EX
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      retire_o <= '0;
    else
    begin
      retire_o.valid   <= id_ex_i.valid;
      retire_o.pc      <= id_ex_i.pc;
      retire_o.rd      <= id_ex_i.rd;
      retire_o.we      <= rf_we;
      retire_o.wdata   <= id_ex_i.illegal ? '0 : alu_result;  // no data on illegal
      retire_o.illegal <= id_ex_i.valid && id_ex_i.illegal;
    end
  end

endmodule

`default_nettype wire

// File: hw/riscv_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_id_stage (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  riscv_pkg::if_id_t                 if_id_i,

  // register file read ports
  output logic [riscv_pkg::REG_ADDR_W-1:0]  raddr_a_o,
  output logic [riscv_pkg::REG_ADDR_W-1:0]  raddr_b_o,
  input  logic [riscv_pkg::XLEN-1:0]        rdata_a_i,
  input  logic [riscv_pkg::XLEN-1:0]        rdata_b_i,

  input  riscv_pkg::rf_wr_t                 bypass_i,   // same-cycle EX write
  output riscv_pkg::id_ex_t                 id_ex_o
);

  logic [riscv_pkg::XLEN-1:0]       instr;
  logic [2:0]                       funct3;
  logic [6:0]                       funct7;
  logic [riscv_pkg::REG_ADDR_W-1:0] rs1;
  logic [riscv_pkg::REG_ADDR_W-1:0] rs2;
  logic [riscv_pkg::XLEN-1:0]       imm_i;
  logic [riscv_pkg::XLEN-1:0]       imm_u;
  logic [riscv_pkg::XLEN-1:0]       rs1_data;
  logic [riscv_pkg::XLEN-1:0]       rs2_data;
  riscv_pkg::alu_op_e               alu_op;
  logic                             use_imm;   // operand b from imm_i
  logic                             is_lui;    // 0 + imm_u
  logic                             illegal;
  riscv_pkg::id_ex_t                id_ex_d;

  assign instr  = if_id_i.instr;
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};  // sign extended
  assign imm_u = {instr[31:12], 12'b0};

  ////////////////////////////////////////////////////////////////////////////
  // decoder
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    alu_op  = riscv_pkg::ALU_ADD;
    use_imm = 1'b0;
    is_lui  = 1'b0;
    illegal = 1'b0;
    case (riscv_pkg::opcode_e'(instr[6:0]))
      riscv_pkg::OPCODE_OP:
      begin
        if (funct7 == 7'b0000000)
        begin
          case (funct3)
            3'b000:  alu_op = riscv_pkg::ALU_ADD;
            3'b001:  alu_op = riscv_pkg::ALU_SLL;
            3'b010:  alu_op = riscv_pkg::ALU_SLT;
            3'b100:  alu_op = riscv_pkg::ALU_XOR;
            3'b101:  alu_op = riscv_pkg::ALU_SRL;
            3'b110:  alu_op = riscv_pkg::ALU_OR;
            3'b111:  alu_op = riscv_pkg::ALU_AND;
            default: illegal = 1'b1;  // sltu
          endcase
        end
        else if (funct7 == 7'b0100000 && funct3 == 3'b000)
          alu_op = riscv_pkg::ALU_SUB;
        else
          illegal = 1'b1;  // sra, M extension etc
      end
      riscv_pkg::OPCODE_OPIMM:
      begin
        use_imm = 1'b1;
        case (funct3)
          3'b000:  alu_op = riscv_pkg::ALU_ADD;
          3'b010:  alu_op = riscv_pkg::ALU_SLT;
          3'b100:  alu_op = riscv_pkg::ALU_XOR;
          3'b110:  alu_op = riscv_pkg::ALU_OR;
          3'b111:  alu_op = riscv_pkg::ALU_AND;
          default: illegal = 1'b1;  // immediate shifts, sltiu
        endcase
      end
      riscv_pkg::OPCODE_LUI: is_lui = 1'b1;
      default:               illegal = 1'b1;
    endcase
  end

  // register reads, newest value from EX wins
  assign raddr_a_o = rs1;
  assign raddr_b_o = rs2;

  assign rs1_data = (bypass_i.we && bypass_i.waddr == rs1 && rs1 != '0)
                    ? bypass_i.wdata : rdata_a_i;
  assign rs2_data = (bypass_i.we && bypass_i.waddr == rs2 && rs2 != '0)
                    ? bypass_i.wdata : rdata_b_i;

  always_comb
  begin
    id_ex_d.valid     = if_id_i.valid;
    id_ex_d.pc        = if_id_i.pc;
    id_ex_d.alu_op    = alu_op;
    id_ex_d.operand_a = is_lui ? '0 : rs1_data;
    id_ex_d.operand_b = is_lui ? imm_u : (use_imm ? imm_i : rs2_data);
    id_ex_d.rd        = instr[11:7];
    id_ex_d.we        = !illegal;  // illegal never writes
    id_ex_d.illegal   = illegal;
  end

  // ID/EX register, no stall
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      id_ex_o <= '0;
    else
      id_ex_o <= id_ex_d;
  end

endmodule

`default_nettype wire

// File: hw/riscv_if_stage.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_if_stage (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        fetch_enable_i,
  input  logic [riscv_pkg::XLEN-1:0]  boot_addr_i,

  // instruction memory, req/gnt/rvalid
  output logic                        instr_req_o,
  output logic [riscv_pkg::XLEN-1:0]  instr_addr_o,
  input  logic                        instr_gnt_i,
  input  logic                        instr_rvalid_i,
  input  logic [riscv_pkg::XLEN-1:0]  instr_rdata_i,

  output riscv_pkg::if_id_t           if_id_o
);

  typedef enum logic [1:0] {
    FETCH_IDLE,         // no request out
    FETCH_WAIT_GNT,     // address phase
    FETCH_WAIT_RVALID   // data phase
  } fetch_state_e;

  fetch_state_e               state_q;
  fetch_state_e               state_d;
  logic [riscv_pkg::XLEN-1:0] pc_q;
  logic [riscv_pkg::XLEN-1:0] pc_d;
  logic                       boot_q;   // pc still waits for boot address
  logic                       word_in;  // data beat this cycle

  assign word_in = (state_q == FETCH_WAIT_RVALID) && instr_rvalid_i;

  // req and addr straight from state, so both hold until gnt
  assign instr_req_o  = (state_q == FETCH_WAIT_GNT);
  assign instr_addr_o = pc_q;

  ////////////////////////////////////////////////////////////////////////////
  // fetch FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    pc_d    = pc_q;
    case (state_q)
      FETCH_IDLE:
      begin
        if (fetch_enable_i)
        begin
          state_d = FETCH_WAIT_GNT;
          if (boot_q)
            pc_d = boot_addr_i;  // first fetch after reset
        end
      end
      FETCH_WAIT_GNT:
      begin
        if (instr_gnt_i)
          state_d = FETCH_WAIT_RVALID;
      end
      FETCH_WAIT_RVALID:
      begin
        if (instr_rvalid_i)
        begin
          pc_d    = pc_q + 32'd4;  // sequential only, no jumps
          state_d = fetch_enable_i ? FETCH_WAIT_GNT : FETCH_IDLE;
        end
      end
      default: state_d = FETCH_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q <= FETCH_IDLE;
      pc_q    <= '0;
      boot_q  <= 1'b1;
    end
    else
    begin
      state_q <= state_d;
      pc_q    <= pc_d;
      if (state_q == FETCH_IDLE && fetch_enable_i)
        boot_q <= 1'b0;
    end
  end

  // fetched word, valid for one cycle only
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      if_id_o.valid <= 1'b0;
      if_id_o.pc    <= '0;
      if_id_o.instr <= riscv_pkg::NOP_INSTR;
    end
    else
    begin
      if_id_o.valid <= word_in;
      if (word_in)
      begin
        if_id_o.pc    <= pc_q;          // addr of the returned word
        if_id_o.instr <= instr_rdata_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/riscv_pkg.sv
`default_nettype none

package riscv_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and constants
  ////////////////////////////////////////////////////////////////////////////

  localparam int XLEN       = 32;  // data and address width
  localparam int REG_ADDR_W = 5;   // x0..x31

  localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;  // addi x0, x0, 0

  // major opcodes still decoded
  typedef enum logic [6:0] {
    OPCODE_OP    = 7'h33,  // register-register
    OPCODE_OPIMM = 7'h13,  // register-immediate
    OPCODE_LUI   = 7'h37
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,  // signed compare
    ALU_SLL,
    ALU_SRL
  } alu_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // pipeline records
  ////////////////////////////////////////////////////////////////////////////

  // fetch -> decode
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr;
  } if_id_t;

  // decode -> execute
  typedef struct packed {
    logic                  valid;
    logic [XLEN-1:0]       pc;
    alu_op_e               alu_op;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [REG_ADDR_W-1:0] rd;
    logic                  we;       // decoder wants a write
    logic                  illegal;
  } id_ex_t;

  // register file write port, also the bypass into decode
  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
  } rf_wr_t;

  // one record per retired instruction
  typedef struct packed {
    logic                  valid;
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rd;
    logic                  we;
    logic [XLEN-1:0]       wdata;
    logic                  illegal;
  } retire_t;

endpackage

`default_nettype wire

// File: hw/riscv_register_file.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_register_file (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic [riscv_pkg::REG_ADDR_W-1:0]  raddr_a_i,
  input  logic [riscv_pkg::REG_ADDR_W-1:0]  raddr_b_i,
  output logic [riscv_pkg::XLEN-1:0]        rdata_a_o,
  output logic [riscv_pkg::XLEN-1:0]        rdata_b_o,
  input  riscv_pkg::rf_wr_t                 wr_i
);

  // x1..x31, x0 not stored
  logic [riscv_pkg::XLEN-1:0] regs_q [1:31];

  // x0 hardwired to zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      for (int i = 1; i < 32; i++)
        regs_q[i] <= '0;
    end
    else if (wr_i.we && wr_i.waddr != '0)  // writes to x0 dropped
      regs_q[wr_i.waddr] <= wr_i.wdata;
  end

endmodule

`default_nettype wire

// File: tb/tb_riscv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_core;

  // one program word and what it must retire with
  typedef struct packed {
    logic [31:0] instr;
    logic [4:0]  rd;
    logic        we;
    logic [31:0] wdata;
    logic        illegal;
  } prog_entry_t;

  logic                       clk_i;
  logic                       arst_n_i;
  logic                       fetch_enable_i;
  logic [riscv_pkg::XLEN-1:0] boot_addr_i;
  logic                       instr_req_o;
  logic [riscv_pkg::XLEN-1:0] instr_addr_o;
  logic                       instr_gnt_i;
  logic                       instr_rvalid_i;
  logic [riscv_pkg::XLEN-1:0] instr_rdata_i;
  riscv_pkg::retire_t         retire_o;

  prog_entry_t prog [$];
  int          rvalid_cycles [$];  // cycle count at each data beat
  int          cycle;
  int          seed;
  int          errors;
  int          stalls;
  int          timeout_cycles;

  riscv_core i_riscv_core (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .retire_o       ( retire_o       )
  );

  always #10 clk_i = ~clk_i;  // 20 ns period

  always @(posedge clk_i)
    cycle <= cycle + 1;

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("error %s: got %h, expected %h", name, actual, expected);
      errors++;
    end
  endtask

  task automatic add_entry(input logic [31:0] instr, input logic [4:0] rd, input logic we,
                           input logic [31:0] wdata, input logic illegal);
    prog.push_back({instr, rd, we, wdata, illegal});
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // program table with expected values worked out from the ISA by hand
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_program();
    add_entry(32'h00500093, 5'd1,  1'b1, 32'h0000_0005, 1'b0);  // addi x1, x0, 5
    add_entry(32'hFFD08113, 5'd2,  1'b1, 32'h0000_0002, 1'b0);  // addi x2, x1, -3
    add_entry(32'h002081B3, 5'd3,  1'b1, 32'h0000_0007, 1'b0);  // add x3, x1, x2
    add_entry(32'h40118233, 5'd4,  1'b1, 32'h0000_0002, 1'b0);  // sub x4, x3, x1
    add_entry(32'h0021F2B3, 5'd5,  1'b1, 32'h0000_0002, 1'b0);  // and x5, x3, x2
    add_entry(32'h0041E333, 5'd6,  1'b1, 32'h0000_0007, 1'b0);  // or x6, x3, x4
    add_entry(32'h0011C3B3, 5'd7,  1'b1, 32'h0000_0002, 1'b0);  // xor x7, x3, x1
    add_entry(32'h00112433, 5'd8,  1'b1, 32'h0000_0001, 1'b0);  // slt x8, x2, x1
    add_entry(32'hFFF00493, 5'd9,  1'b1, 32'hFFFF_FFFF, 1'b0);  // addi x9, x0, -1
    add_entry(32'h0004A533, 5'd10, 1'b1, 32'h0000_0001, 1'b0);  // signed slt x10, x9, x0
    add_entry(32'h002095B3, 5'd11, 1'b1, 32'h0000_0014, 1'b0);  // sll x11, x1, x2
    add_entry(32'h0014D633, 5'd12, 1'b1, 32'h07FF_FFFF, 1'b0);  // srl x12, x9, x1
    add_entry(32'h0F04F693, 5'd13, 1'b1, 32'h0000_00F0, 1'b0);  // andi x13, x9, 0xf0
    add_entry(32'h1000E713, 5'd14, 1'b1, 32'h0000_0105, 1'b0);  // ori x14, x1, 0x100
    add_entry(32'hFFF1C793, 5'd15, 1'b1, 32'hFFFF_FFF8, 1'b0);  // xori x15, x3, -1
    add_entry(32'h0014A813, 5'd16, 1'b1, 32'h0000_0001, 1'b0);  // slti x16, x9, 1
    add_entry(32'h123458B7, 5'd17, 1'b1, 32'h1234_5000, 1'b0);  // lui x17, 0x12345
    add_entry(32'h67888A13, 5'd20, 1'b1, 32'h1234_5678, 1'b0);  // addi x20, x17, 0x678
    add_entry(32'h00908013, 5'd0,  1'b0, 32'h0000_0000, 1'b0);  // addi x0, x1, 9 writes nothing
    add_entry(32'h00100933, 5'd18, 1'b1, 32'h0000_0005, 1'b0);  // add x18, x0, x1
    add_entry(32'h0000A283, 5'd5,  1'b0, 32'h0000_0000, 1'b1);  // lw x5 is not decoded
    add_entry(32'h00128993, 5'd19, 1'b1, 32'h0000_0003, 1'b0);  // addi x19, x5, 1 sees x5 = 2
  endtask

  task automatic wait_for_request();
    int cnt;
    cnt = 0;
    while (!instr_req_o && stalls == 0)
    begin
      @(negedge clk_i);
      cnt++;
      if (cnt > timeout_cycles)
      begin
        $display("fetch stalled, no instruction request within %0d cycles", timeout_cycles);
        stalls++;
      end
    end
  endtask

  task automatic wait_for_retire();
    int cnt;
    cnt = 0;
    while (!retire_o.valid && stalls == 0)
    begin
      @(negedge clk_i);
      cnt++;
      if (cnt > timeout_cycles)
      begin
        $display("pipeline stalled, no retire within %0d cycles", timeout_cycles);
        stalls++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // instruction memory model with random gnt and rvalid delays
  ////////////////////////////////////////////////////////////////////////////

  task automatic serve_fetches();
    int          gnt_delay;
    int          rvalid_delay;
    int          idx;
    logic [31:0] addr;
    for (int k = 0; k < prog.size(); k++)
    begin
      wait_for_request();
      if (stalls != 0)
        break;
      addr = instr_addr_o;
      check_value("instr_addr_o", addr, boot_addr_i + 32'(4 * k));  // sequential pc
      gnt_delay = $unsigned($random(seed)) % 4;  // 0..3
      repeat (gnt_delay)
      begin
        @(negedge clk_i);
        check_value("instr_req_o", 32'(instr_req_o), 32'd1);  // held until gnt
        check_value("instr_addr_o", instr_addr_o, addr);
      end
      instr_gnt_i = 1'b1;
      @(negedge clk_i);
      instr_gnt_i  = 1'b0;
      rvalid_delay = 1 + $unsigned($random(seed)) % 3;  // 1..3 after gnt
      check_value("instr_req_o", 32'(instr_req_o), 32'd0);  // one in flight
      repeat (rvalid_delay - 1)
      begin
        @(negedge clk_i);
        check_value("instr_req_o", 32'(instr_req_o), 32'd0);
      end
      idx            = (addr - boot_addr_i) >> 2;
      instr_rvalid_i = 1'b1;
      if (idx >= 0 && idx < prog.size())
        instr_rdata_i = prog[idx].instr;
      else
      begin
        $display("fetch address %h lies outside the program", addr);
        errors++;
        instr_rdata_i = riscv_pkg::NOP_INSTR;
      end
      rvalid_cycles.push_back(cycle);
      if (k == prog.size() - 1)
        fetch_enable_i = 1'b0;  // fetch goes idle after the last word
      @(negedge clk_i);
      instr_rvalid_i = 1'b0;
    end
  endtask

  // one retire record per table entry in program order
  task automatic check_retires();
    int t_rvalid;
    for (int k = 0; k < prog.size(); k++)
    begin
      wait_for_retire();
      if (stalls != 0)
        break;
      check_value("retire_o.pc", retire_o.pc, boot_addr_i + 32'(4 * k));
      check_value("retire_o.rd", 32'(retire_o.rd), 32'(prog[k].rd));
      check_value("retire_o.we", 32'(retire_o.we), 32'(prog[k].we));
      check_value("retire_o.illegal", 32'(retire_o.illegal), 32'(prog[k].illegal));
      if (prog[k].we || prog[k].illegal)  // illegal retires carry no data
        check_value("retire_o.wdata", retire_o.wdata, prog[k].wdata);
      if (rvalid_cycles.size() == 0)
      begin
        $display("retire %0d showed up before its instruction was fetched", k);
        errors++;
      end
      else
      begin
        t_rvalid = rvalid_cycles.pop_front();
        check_value("retire latency", 32'(cycle - t_rvalid), 32'd3);  // IF, ID/EX and retire
      end
      @(negedge clk_i);
    end
  endtask

  initial
  begin
    clk_i          = 1'b0;
    arst_n_i       = 1'b0;
    fetch_enable_i = 1'b0;
    boot_addr_i    = 32'h0000_0100;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = riscv_pkg::NOP_INSTR;
    cycle          = 0;
    seed           = 32'hbc13be42;
    errors         = 0;
    stalls         = 0;
    timeout_cycles = 50;
    load_program();

    repeat (2) @(negedge clk_i);
    arst_n_i = 1'b1;
    check_value("retire_o.valid", 32'(retire_o.valid), 32'd0);
    check_value("retire_o.pc", retire_o.pc, 32'd0);

    // core must stay quiet while fetch is disabled
    repeat (5)
    begin
      @(negedge clk_i);
      check_value("instr_req_o", 32'(instr_req_o), 32'd0);
      check_value("retire_o.valid", 32'(retire_o.valid), 32'd0);
    end
    fetch_enable_i = 1'b1;

    fork
      serve_fetches();
      check_retires();
    join

    // nothing more may come out once drained
    if (stalls == 0)
    begin
      repeat (5)
      begin
        @(negedge clk_i);
        check_value("instr_req_o", 32'(instr_req_o), 32'd0);
        check_value("retire_o.valid", 32'(retire_o.valid), 32'd0);
      end
    end

    $display("%0d errors, %0d stalls", errors, stalls);
    if (errors == 0 && stalls == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire
